// File: flist.f
+incdir+common
common/enc_pkg.sv
source/enc_input_sync.sv
source/enc_quad_decoder.sv
enc_period/enc_edge_period.sv
enc_period/enc_period_quad.sv
source/enc_channel_top.sv
sim/tb_enc_channel.sv

// File: run_sim.sh
#!/bin/sh
# build and run the encoder channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_enc_channel

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module "$TOP" \
    -Mdir obj_dir \
    -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the run passes only if the testbench printed its pass line
if grep -qx "all tests passed" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: sim/tb_enc_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "enc_macros.svh"

module tb_enc_channel
    import enc_pkg::*;
();

    // phase lengths in clk_fast cycles
    localparam int RESET_CYC    = 5;
    localparam int MAX_HOLD     = 60;
    localparam int WALK_STEPS   = 400;
    localparam int BURST_STEPS  = 300;
    localparam int ERR_TOGGLES  = 6;
    localparam int ERR_HOLD     = 8;
    localparam int SAT_HOLD     = 40000;
    localparam int RESUME_STEPS = 50;
    localparam int SETTLE       = 20;
    localparam int POST_STEPS   = 100;
    localparam int DRAIN        = 20;
    localparam int RUN_CYC      = RESET_CYC + WALK_STEPS * MAX_HOLD + BURST_STEPS + SETTLE
                                + ERR_TOGGLES * ERR_HOLD + SAT_HOLD + RESUME_STEPS * MAX_HOLD
                                + RESET_CYC + SETTLE + POST_STEPS * MAX_HOLD + DRAIN;
    localparam int CYCLE_LIMIT  = RUN_CYC + 1000;

    logic                             clk_fast;
    logic                             reset;
    logic                             a;
    logic                             b;
    logic signed [`ENC_POS_WIDTH-1:0] position;
    logic                             dir;
    logic                             quad_error;
    enc_period_t                      period;

    integer seed = 32'hf6e2_d392;
    integer cycles = 0;
    integer checks = 0;
    integer value_errors = 0;
    integer other_errors = 0;
    integer qerr_seen = 0;
    int     gray_idx;   // position in forward sequence 00,10,11,01
    int     walk_dir;   // +1 forward, -1 reverse

    // ------------------------------------------------------------
    // reference model state
    // ------------------------------------------------------------
    logic [2:0]                       ma_pipe;
    logic [2:0]                       mb_pipe;
    logic [3:0]                       m_strobe;  // a rise, a fall, b rise, b fall
    logic signed [`ENC_POS_WIDTH-1:0] m_pos;
    logic                             m_dir;
    logic                             m_qerr;
    logic [`ENC_CNT_WIDTH-1:0]        m_run [4];
    logic [`ENC_CNT_WIDTH-1:0]        m_lat [4];
    logic                             m_ldir [4];
    logic [1:0]                       m_sel;
    enc_period_t                      m_period;

    enc_channel_top enc_channel_top_i (
        .clk_fast   (clk_fast),
        .reset      (reset),
        .a          (a),
        .b          (b),
        .position   (position),
        .dir        (dir),
        .quad_error (quad_error),
        .period     (period)
    );

    initial begin
        clk_fast = 1'b0;
        forever #2 clk_fast = ~clk_fast;  // 4 ns period
    end

    // index of a level pair in the forward walk
    function automatic int gray_index(input logic av, input logic bv);
        case ({av, bv})
            2'b00:   return 0;
            2'b10:   return 1;
            2'b11:   return 2;
            default: return 3;
        endcase
    endfunction

    task automatic model_reset();
        int k;
        ma_pipe  = 3'b000;
        mb_pipe  = 3'b000;
        m_strobe = 4'b0000;
        m_pos    = '0;
        m_dir    = 1'b0;
        m_qerr   = 1'b0;
        m_sel    = 2'd0;
        m_period = '0;
        for (k = 0; k < 4; k++) begin
            m_run[k]  = '0;
            m_lat[k]  = '0;
            m_ldir[k] = 1'b1;  // forward assumed before any edge
        end
    endtask

    task automatic model_clock();
        logic a_chg;
        logic b_chg;
        logic old_a;
        logic old_b;
        logic valid;
        logic fwd;
        int   k;
        a_chg = m_strobe[0] | m_strobe[1];
        b_chg = m_strobe[2] | m_strobe[3];
        valid = a_chg ^ b_chg;
        old_a = ma_pipe[2] ^ a_chg;  // level before this strobe
        old_b = mb_pipe[2] ^ b_chg;
        fwd   = gray_index(ma_pipe[2], mb_pipe[2]) == ((gray_index(old_a, old_b) + 1) % 4);
        // output stage sees old select and old counters
        m_period.running = m_run[m_sel];
        m_period.latched = m_lat[m_sel];
        for (k = 0; k < 4; k++) begin
            if (m_strobe[k]) begin
                m_lat[k] = (!valid || fwd != m_ldir[k]) ? `ENC_OVERFLOW : m_run[k];
                if (valid)
                    m_ldir[k] = fwd;
                m_run[k] = '0;
            end else if (m_run[k] != `ENC_OVERFLOW) begin
                m_run[k] = m_dir ? m_run[k] + 16'd1 : m_run[k] - 16'd1;  // old dir
            end
        end
        if (m_strobe[0])
            m_sel = 2'd0;
        else if (m_strobe[1])
            m_sel = 2'd1;
        else if (m_strobe[2])
            m_sel = 2'd2;
        else if (m_strobe[3])
            m_sel = 2'd3;
        m_qerr = a_chg & b_chg;
        if (valid) begin
            m_pos = fwd ? m_pos + 32'sd1 : m_pos - 32'sd1;
            m_dir = fwd;
        end
        // strobes from stage 2 vs history before the shift
        m_strobe[0] = ma_pipe[1] & ~ma_pipe[2];
        m_strobe[1] = ~ma_pipe[1] & ma_pipe[2];
        m_strobe[2] = mb_pipe[1] & ~mb_pipe[2];
        m_strobe[3] = ~mb_pipe[1] & mb_pipe[2];
        ma_pipe = {ma_pipe[1:0], a};
        mb_pipe = {mb_pipe[1:0], b};
    endtask

    always @(posedge clk_fast or negedge reset) begin
        if (!reset)
            model_reset();
        else
            model_clock();
    end

    // ------------------------------------------------------------
    // checking
    // ------------------------------------------------------------
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            value_errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // outputs settled half a cycle after the edge
    always @(negedge clk_fast) begin
        if (cycles > 0) begin
            check_value("position", position, m_pos);
            check_value("dir", {31'b0, dir}, {31'b0, m_dir});
            check_value("quad_error", {31'b0, quad_error}, {31'b0, m_qerr});
            check_value("period", period, m_period);
            if (quad_error)
                qerr_seen++;
        end
    end

    always @(posedge clk_fast) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_fast);
        #1;  // drive point after the edge
    endtask

    task automatic drive_lines();
        case (gray_idx)
            0:       begin a = 1'b0; b = 1'b0; end
            1:       begin a = 1'b1; b = 1'b0; end
            2:       begin a = 1'b1; b = 1'b1; end
            default: begin a = 1'b0; b = 1'b1; end
        endcase
    endtask

    task automatic walk_steps(input int steps, input int min_hold, input int max_hold);
        int hold;
        repeat (steps) begin
            if (($random(seed) & 7) == 0)
                walk_dir = -walk_dir;  // reversal with probability 1 in 8
            gray_idx = (gray_idx + walk_dir) & 3;
            drive_lines();
            hold = min_hold + ($unsigned($random(seed)) % (max_hold - min_hold + 1));
            wait_cycles(hold);
        end
    endtask

    // both lines flip at once
    task automatic toggle_both(input int times);
        repeat (times) begin
            gray_idx = (gray_idx + 2) & 3;
            drive_lines();
            wait_cycles(ERR_HOLD);
        end
    endtask

    initial begin
        a        = 1'b0;
        b        = 1'b0;
        reset    = 1'b0;
        gray_idx = 0;
        walk_dir = 1;
        wait_cycles(RESET_CYC);
        reset = 1'b1;

        walk_steps(WALK_STEPS, 4, MAX_HOLD);   // normal motion
        walk_steps(BURST_STEPS, 1, 1);         // one edge per cycle
        wait_cycles(SETTLE);
        toggle_both(ERR_TOGGLES);

        // long hold where counters must stop at the marker
        walk_steps(1, SAT_HOLD, SAT_HOLD);
        check_value("running after long hold", {16'b0, period.running},
                    {16'b0, `ENC_OVERFLOW});
        walk_steps(RESUME_STEPS, 4, MAX_HOLD);

        // reset in mid-run with a held high
        reset    = 1'b0;
        gray_idx = 1;
        walk_dir = 1;
        drive_lines();
        wait_cycles(1);
        check_value("position in reset", position, 32'd0);
        check_value("period in reset", period, 32'd0);
        wait_cycles(RESET_CYC - 1);
        reset = 1'b1;
        wait_cycles(SETTLE);
        check_value("position after a rise", position, 32'd1);  // a up with b low
        check_value("dir after a rise", {31'b0, dir}, 32'd1);

        walk_steps(POST_STEPS, 4, MAX_HOLD);
        wait_cycles(DRAIN);

        assert (qerr_seen > 0) else begin
            other_errors++;
            $display("no quad_error pulse was seen during the run");
        end
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/enc_channel_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "enc_macros.svh"

module enc_channel_top
    import enc_pkg::*;
(
    input  logic                            clk_fast,
    input  logic                            reset,      // async, active low
    input  logic                            a,
    input  logic                            b,
    output logic signed [`ENC_POS_WIDTH-1:0] position,
    output logic                            dir,
    output logic                            quad_error,
    output enc_period_t                     period
);

    enc_edges_t edges;  // strobes + synced levels
    enc_step_t  step;   // same-cycle step decode

    enc_input_sync u_input_sync (
        .clk_fast (clk_fast),
        .reset    (reset),
        .a        (a),
        .b        (b),
        .edges    (edges)
    );

    enc_quad_decoder u_quad_decoder (
        .clk_fast   (clk_fast),
        .reset      (reset),
        .edges      (edges),
        .step       (step),
        .position   (position),
        .dir        (dir),
        .quad_error (quad_error)
    );

    // period block counts with the registered dir
    enc_period_quad u_period_quad (
        .clk_fast (clk_fast),
        .reset    (reset),
        .edges    (edges),
        .step     (step),
        .dir      (dir),
        .period   (period)
    );

endmodule

`default_nettype wire

// File: enc_period/enc_period_quad.sv
`timescale 1ns/1ps
`default_nettype none

module enc_period_quad
    import enc_pkg::*;
(
    input  logic        clk_fast,
    input  logic        reset,
    input  enc_edges_t  edges,
    input  enc_step_t   step,
    input  logic        dir,
    output enc_period_t period
);

    enc_period_t meas [4];  // indexed by edge kind
    logic [1:0]  sel;       // kind of the latest edge

    // ------------------------------------------------------------
    // one counter per edge kind
    // ------------------------------------------------------------
    enc_edge_period u_a_rise (
        .clk_fast    (clk_fast),
        .reset       (reset),
        .edge_strobe (edges.a_rise),
        .step        (step),
        .dir         (dir),
        .measure     (meas[0])
    );

    enc_edge_period u_a_fall (
        .clk_fast    (clk_fast),
        .reset       (reset),
        .edge_strobe (edges.a_fall),
        .step        (step),
        .dir         (dir),
        .measure     (meas[1])
    );

    enc_edge_period u_b_rise (
        .clk_fast    (clk_fast),
        .reset       (reset),
        .edge_strobe (edges.b_rise),
        .step        (step),
        .dir         (dir),
        .measure     (meas[2])
    );

    enc_edge_period u_b_fall (
        .clk_fast    (clk_fast),
        .reset       (reset),
        .edge_strobe (edges.b_fall),
        .step        (step),
        .dir         (dir),
        .measure     (meas[3])
    );

    // ------------------------------------------------------------
    // latest-edge select, a first on a tie
    // ------------------------------------------------------------
    always_ff @(posedge clk_fast or negedge reset) begin
        if (!reset)
            sel <= 2'd0;
        else if (edges.a_rise)
            sel <= 2'd0;
        else if (edges.a_fall)
            sel <= 2'd1;
        else if (edges.b_rise)
            sel <= 2'd2;
        else if (edges.b_fall)
            sel <= 2'd3;
    end

    // output stage, follows sel and the counters by one cycle
    always_ff @(posedge clk_fast or negedge reset) begin
        if (!reset)
            period <= '0;
        else
            period <= meas[sel];
    end

endmodule

`default_nettype wire

// File: enc_period/enc_edge_period.sv
`timescale 1ns/1ps
`default_nettype none

`include "enc_macros.svh"

module enc_edge_period
    import enc_pkg::*;
(
    input  logic        clk_fast,
    input  logic        reset,
    input  logic        edge_strobe,  // one edge of this counter's kind
    input  enc_step_t   step,         // step decoded on the strobe cycle
    input  logic        dir,          // registered direction from decoder
    output enc_period_t measure
);

    logic [`ENC_CNT_WIDTH-1:0] running;
    logic [`ENC_CNT_WIDTH-1:0] latched;
    logic                      last_dir;   // step dir at previous own edge
    logic                      dir_break;  // reversal or error on this edge

    // error strobe counts as a reversal
    assign dir_break = ~step.valid | (step.dir != last_dir);

    // ------------------------------------------------------------
    // running count, saturates at the overflow marker
    // ------------------------------------------------------------
    always_ff @(posedge clk_fast or negedge reset) begin
        if (!reset) begin
            running <= '0;
        end else if (edge_strobe) begin
            running <= '0;  // new period starts
        end else if (running != `ENC_OVERFLOW) begin
            if (dir)
                running <= running + 1'b1;  // 7fff -> 8000 then hold
            else
                running <= running - 1'b1;  // 0 -> ffff ... 8000
        end
    end

    // ------------------------------------------------------------
    // latch on own edge
    // ------------------------------------------------------------
    always_ff @(posedge clk_fast or negedge reset) begin
        if (!reset) begin
            latched  <= '0;
            last_dir <= 1'b1;
        end else if (edge_strobe) begin
            if (dir_break)
                latched <= `ENC_OVERFLOW;  // period not meaningful
            else
                latched <= running;
            if (step.valid)
                last_dir <= step.dir;      // kept across an error
        end
    end

    assign measure.running = running;
    assign measure.latched = latched;

endmodule

`default_nettype wire

// File: source/enc_quad_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "enc_macros.svh"

module enc_quad_decoder
    import enc_pkg::*;
(
    input  logic                            clk_fast,
    input  logic                            reset,
    input  enc_edges_t                      edges,
    output enc_step_t                       step,
    output logic signed [`ENC_POS_WIDTH-1:0] position,
    output logic                            dir,
    output logic                            quad_error
);

    logic a_chg;    // a toggled this cycle
    logic b_chg;    // b toggled this cycle
    logic fwd;      // forward decode of the change
    logic both_chg; // illegal transition

    // ------------------------------------------------------------
    // combinational step decode
    // ------------------------------------------------------------
    assign a_chg    = edges.a_rise | edges.a_fall;
    assign b_chg    = edges.b_rise | edges.b_fall;
    assign both_chg = a_chg & b_chg;

    // a leading b counts as forward
    assign fwd = (edges.a_rise & ~edges.b_s) |
                 (edges.a_fall &  edges.b_s) |
                 (edges.b_rise &  edges.a_s) |
                 (edges.b_fall & ~edges.a_s);

    assign step.valid = a_chg ^ b_chg;  // exactly one line moved
    assign step.dir   = fwd;

    // ------------------------------------------------------------
    // position and direction registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_fast or negedge reset) begin
        if (!reset) begin
            position <= '0;
            dir      <= 1'b0;
        end else if (step.valid) begin
            if (step.dir)
                position <= position + 1'b1;  // wraps in two's complement
            else
                position <= position - 1'b1;
            dir <= step.dir;
        end
    end

    // one pulse per double change while position holds above
    always_ff @(posedge clk_fast or negedge reset) begin
        if (!reset)
            quad_error <= 1'b0;
        else
            quad_error <= both_chg;
    end

endmodule

`default_nettype wire

// File: source/enc_input_sync.sv
`timescale 1ns/1ps
`default_nettype none

module enc_input_sync
    import enc_pkg::*;
(
    input  logic       clk_fast,
    input  logic       reset,     // async, active low
    input  logic       a,         // raw encoder line a
    input  logic       b,         // raw encoder line b
    output enc_edges_t edges
);

    logic [2:0] a_pipe;  // [0],[1] metastability, [2] history
    logic [2:0] b_pipe;

    // ------------------------------------------------------------
    // three-stage shift per line
    // ------------------------------------------------------------
    always_ff @(posedge clk_fast or negedge reset) begin
        if (!reset) begin
            a_pipe <= 3'b000;  // a line held high gives a rise after release
            b_pipe <= 3'b000;
        end else begin
            a_pipe <= {a_pipe[1:0], a};
            b_pipe <= {b_pipe[1:0], b};
        end
    end

    // strobes come from stage 2 vs stage 3, registered once so that
    // the strobe lands in the cycle after the third edge
    always_ff @(posedge clk_fast or negedge reset) begin
        if (!reset) begin
            edges.a_rise <= 1'b0;
            edges.a_fall <= 1'b0;
            edges.b_rise <= 1'b0;
            edges.b_fall <= 1'b0;
        end else begin
            edges.a_rise <= a_pipe[1] & ~a_pipe[2];
            edges.a_fall <= ~a_pipe[1] & a_pipe[2];
            edges.b_rise <= b_pipe[1] & ~b_pipe[2];
            edges.b_fall <= ~b_pipe[1] & b_pipe[2];
        end
    end

    // history stage now holds the new level, aligned with the strobes
    assign edges.a_s = a_pipe[2];
    assign edges.b_s = b_pipe[2];

endmodule

`default_nettype wire

// File: common/enc_pkg.sv
`default_nettype none

`include "enc_macros.svh"

package enc_pkg;

    // ------------------------------------------------------------
    // synchronized encoder lines
    // ------------------------------------------------------------
    typedef struct packed {
        logic a_rise;   // one-cycle strobes
        logic a_fall;
        logic b_rise;
        logic b_fall;
        logic a_s;      // synchronized level of a
        logic b_s;      // synchronized level of b
    } enc_edges_t;

    // quadrature step decoded for a single-line change
    typedef struct packed {
        logic valid;
        logic dir;      // 1 = forward (a leads)
    } enc_step_t;

    // ------------------------------------------------------------
    // period word with the running count in the upper half
    // ------------------------------------------------------------
    typedef struct packed {
        logic [`ENC_CNT_WIDTH-1:0] running;  // live count since last edge
        logic [`ENC_CNT_WIDTH-1:0] latched;  // previous full period
    } enc_period_t;

endpackage

`default_nettype wire

// File: common/enc_macros.svh
`ifndef ENC_MACROS_SVH
`define ENC_MACROS_SVH

// ------------------------------------------------------------
// encoder channel sizing
// ------------------------------------------------------------

// one edge-period counter, signed
`define ENC_CNT_WIDTH 16

// most negative 16-bit value, marks overflow / invalid period
`define ENC_OVERFLOW 16'h8000

// signed position counter
`define ENC_POS_WIDTH 32

`endif
